/* bru_macros.svh */
/*
 * Width constants for the branch resolution unit.
 * Include this header in any file that sizes a datapath, PC or tag field.
 */

`ifndef BRU_MACROS_SVH
`define BRU_MACROS_SVH

// ======================================================================
// Datapath and PC widths
// ======================================================================

// Full integer operand width, the widest compare the unit performs
`define BRU_DATA_W 64

// Program counter width as seen by the back end
`define BRU_PC_W 32

// Signed branch displacement carried in the micro-op word
`define BRU_DISP_W 16

// ======================================================================
// Instruction stream constants
// ======================================================================

// Fall-through distance for a branch that is not taken
`define BRU_INSN_BYTES 4

// Reorder tag width, enough for 64 micro-ops in flight in the core
`define BRU_TAG_W 6

`endif

/* bru_pkg.sv */
/*
 * Shared types for the branch resolution unit.
 * Modules refer to these by scoped name, for example bru_pkg::micro_op_t.
 */

`include "bru_macros.svh"

package bru_pkg;

	// ======================================================================
	// Opcodes
	// ======================================================================

	// Only the eight conditional branch forms are decoded here
	// Any other encoding reaching the unit is treated as not a branch
	typedef enum logic [6:0] {
		OP_BCC8   = 7'h30,
		OP_BCC16  = 7'h31,
		OP_BCC32  = 7'h32,
		OP_BCC64  = 7'h33,
		OP_BCCU8  = 7'h34,
		OP_BCCU16 = 7'h35,
		OP_BCCU32 = 7'h36,
		OP_BCCU64 = 7'h37
	} opcode_t;

	// ======================================================================
	// Condition codes
	// ======================================================================

	// Ordered compares follow the signedness of the opcode family
	// FS and FC test only the flag operand c
	typedef enum logic [2:0] {
		EQ = 3'd0,
		NE = 3'd1,
		LT = 3'd2,
		GE = 3'd3,
		LE = 3'd4,
		GT = 3'd5,
		FS = 3'd6,
		FC = 3'd7
	} cond_t;

	// ======================================================================
	// Micro-op word
	// ======================================================================

	// Generic view used when only the opcode matters
	typedef struct packed {
		opcode_t     opcode;
		logic [24:0] payload;
	} uop_any_t;

	// Branch view with condition and signed displacement
	typedef struct packed {
		opcode_t                       opcode;
		cond_t                         cond;
		logic [5:0]                    spare;
		logic signed [`BRU_DISP_W-1:0] disp;
	} uop_br_t;

	// Both views overlay the same 32-bit word
	typedef union packed {
		uop_any_t any;
		uop_br_t  br;
	} micro_op_t;

endpackage

/* bru_issue_queue.sv */
/*
 * Two-entry micro-op queue on the input side of the branch unit.
 * Accepts issue on in_valid/in_ready and presents the head on q_valid/q_ready.
 */

`timescale 1ns/1ps
`include "bru_macros.svh"

module bru_issue_queue (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   in_valid,
	input  logic [`BRU_TAG_W-1:0]  in_tag,
	input  logic [`BRU_PC_W-1:0]   in_pc,
	input  logic                   in_pred_taken,
	input  bru_pkg::micro_op_t     in_uop,
	input  logic [`BRU_DATA_W-1:0] in_a,
	input  logic [`BRU_DATA_W-1:0] in_b,
	input  logic                   in_c,
	output logic                   in_ready,
	output logic                   q_valid,
	output logic [`BRU_TAG_W-1:0]  q_tag,
	output logic [`BRU_PC_W-1:0]   q_pc,
	output logic                   q_pred_taken,
	output bru_pkg::micro_op_t     q_uop,
	output logic [`BRU_DATA_W-1:0] q_a,
	output logic [`BRU_DATA_W-1:0] q_b,
	output logic                   q_c,
	input  logic                   q_ready
);

	// Entry storage holds one slot per queue position
	logic [`BRU_TAG_W-1:0]  tag_mem  [2];
	logic [`BRU_PC_W-1:0]   pc_mem   [2];
	logic                   pred_mem [2];
	bru_pkg::micro_op_t     uop_mem  [2];
	logic [`BRU_DATA_W-1:0] a_mem    [2];
	logic [`BRU_DATA_W-1:0] b_mem    [2];
	logic                   c_mem    [2];

	logic       wr_ptr;
	logic       rd_ptr;
	logic [1:0] count;
	logic       push;
	logic       pop;

	// A full queue still takes a new entry when the head leaves this cycle
	assign in_ready = (count != 2'd2) || q_ready;
	assign q_valid  = (count != 2'd0);

	assign push = in_valid && in_ready;
	assign pop  = q_valid && q_ready;

	// Head of queue goes straight out to the evaluator
	assign q_tag        = tag_mem[rd_ptr];
	assign q_pc         = pc_mem[rd_ptr];
	assign q_pred_taken = pred_mem[rd_ptr];
	assign q_uop        = uop_mem[rd_ptr];
	assign q_a          = a_mem[rd_ptr];
	assign q_b          = b_mem[rd_ptr];
	assign q_c          = c_mem[rd_ptr];

	// Pointers and occupancy
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count  <= 2'd0;
		end else begin
			if (push)
				wr_ptr <= ~wr_ptr;
			if (pop)
				rd_ptr <= ~rd_ptr;
			// Count moves only when exactly one side fires
			if (push && !pop)
				count <= count + 2'd1;
			else if (pop && !push)
				count <= count - 2'd1;
		end
	end

	// The accepted micro-op is written into the entry at the write pointer
	always_ff @(posedge clk) begin
		if (push) begin
			tag_mem[wr_ptr]  <= in_tag;
			pc_mem[wr_ptr]   <= in_pc;
			pred_mem[wr_ptr] <= in_pred_taken;
			uop_mem[wr_ptr]  <= in_uop;
			a_mem[wr_ptr]    <= in_a;
			b_mem[wr_ptr]    <= in_b;
			c_mem[wr_ptr]    <= in_c;
		end
	end

endmodule

/* bru_cond_eval.sv */
/*
 * Branch condition evaluator at a single operand width.
 * Combinational, instantiated once per width by the meta evaluator.
 */

`timescale 1ns/1ps

module bru_cond_eval #(
	parameter int WID = 64
) (
	input  bru_pkg::micro_op_t uop,
	input  logic [WID-1:0]     a,
	input  logic [WID-1:0]     b,
	input  logic               c,
	output logic               takb
);

	logic is_unsigned;
	logic eq;
	logic lt_s;
	logic lt_u;
	logic lt;

	// ======================================================================
	// Signedness from the opcode family
	// ======================================================================

	// The U forms compare as unsigned, everything else as two's complement
	always_comb begin
		case (uop.br.opcode)
			bru_pkg::OP_BCCU8,
			bru_pkg::OP_BCCU16,
			bru_pkg::OP_BCCU32,
			bru_pkg::OP_BCCU64:
				is_unsigned = 1'b1;
			default:
				is_unsigned = 1'b0;
		endcase
	end

	// ======================================================================
	// Basic compares at WID bits
	// ======================================================================

	assign eq   = (a == b);
	assign lt_s = ($signed(a) < $signed(b));
	assign lt_u = (a < b);

	// Pick the ordering that matches the opcode
	assign lt = is_unsigned ? lt_u : lt_s;

	// ======================================================================
	// Condition select
	// ======================================================================

	// LE and GT are built from lt and eq so one comparator serves all four
	// The flag tests never look at a or b
	always_comb begin
		case (uop.br.cond)
			bru_pkg::EQ: takb = eq;
			bru_pkg::NE: takb = !eq;
			bru_pkg::LT: takb = lt;
			bru_pkg::GE: takb = !lt;
			bru_pkg::LE: takb = lt || eq;
			bru_pkg::GT: takb = !(lt || eq);
			bru_pkg::FS: takb = c;
			bru_pkg::FC: takb = !c;
			default:     takb = 1'b0;
		endcase
	end

endmodule

/* bru_meta_eval.sv */
/*
 * Width-selecting branch evaluator.
 * Runs the condition at 8, 16, 32 and 64 bits and keeps the one the opcode names.
 */

`timescale 1ns/1ps
`include "bru_macros.svh"

module bru_meta_eval (
	input  bru_pkg::micro_op_t     uop,
	input  logic [`BRU_DATA_W-1:0] a,
	input  logic [`BRU_DATA_W-1:0] b,
	input  logic                   c,
	output logic                   takb
);

	logic takb8;
	logic takb16;
	logic takb32;
	logic takb64;

	// Each width has its own evaluator that sees only the low bits of the operands
	bru_cond_eval #(.WID(8))  u_eval8  (.uop(uop), .a(a[7:0]),  .b(b[7:0]),  .c(c), .takb(takb8));
	bru_cond_eval #(.WID(16)) u_eval16 (.uop(uop), .a(a[15:0]), .b(b[15:0]), .c(c), .takb(takb16));
	bru_cond_eval #(.WID(32)) u_eval32 (.uop(uop), .a(a[31:0]), .b(b[31:0]), .c(c), .takb(takb32));
	bru_cond_eval #(.WID(64)) u_eval64 (.uop(uop), .a(a[63:0]), .b(b[63:0]), .c(c), .takb(takb64));

	// Signed and unsigned forms of a width share the same evaluator output
	// Anything that is not a branch opcode falls through as not taken
	always_comb begin
		case (uop.any.opcode)
			bru_pkg::OP_BCC8,  bru_pkg::OP_BCCU8:
				takb = takb8;
			bru_pkg::OP_BCC16, bru_pkg::OP_BCCU16:
				takb = takb16;
			bru_pkg::OP_BCC32, bru_pkg::OP_BCCU32:
				takb = takb32;
			bru_pkg::OP_BCC64, bru_pkg::OP_BCCU64:
				takb = takb64;
			default:
				takb = 1'b0;
		endcase
	end

endmodule

/* bru_resolve.sv */
/*
 * Output side of the branch unit with target math and misprediction check.
 * Holds one registered result and drives back-pressure to the issue queue.
 */

`timescale 1ns/1ps
`include "bru_macros.svh"

module bru_resolve (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  q_valid,
	input  logic [`BRU_TAG_W-1:0] q_tag,
	input  logic [`BRU_PC_W-1:0]  q_pc,
	input  logic                  q_pred_taken,
	input  bru_pkg::micro_op_t    q_uop,
	input  logic                  takb,
	output logic                  q_ready,
	output logic                  out_valid,
	output logic [`BRU_TAG_W-1:0] out_tag,
	output logic                  out_taken,
	output logic [`BRU_PC_W-1:0]  out_next_pc,
	output logic                  out_mispredict,
	input  logic                  out_ready
);

	logic [`BRU_PC_W-1:0] disp_ext;
	logic [`BRU_PC_W-1:0] target;
	logic [`BRU_PC_W-1:0] fall_thru;
	logic [`BRU_PC_W-1:0] next_pc;
	logic                 load;

	// ======================================================================
	// Next PC
	// ======================================================================

	// Displacement is sign extended up to the PC width before the add
	assign disp_ext = {{(`BRU_PC_W-`BRU_DISP_W){q_uop.br.disp[`BRU_DISP_W-1]}}, q_uop.br.disp};

	assign target    = q_pc + disp_ext;
	assign fall_thru = q_pc + `BRU_PC_W'(`BRU_INSN_BYTES);
	assign next_pc   = takb ? target : fall_thru;

	// ======================================================================
	// Output slot and back-pressure
	// ======================================================================

	// Slot can take a new result when empty or when it drains this cycle
	assign q_ready = !out_valid || out_ready;
	assign load    = q_valid && q_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else if (load)
			out_valid <= 1'b1;
		else if (out_ready)
			out_valid <= 1'b0;
	end

	// The result payload is captured whenever the slot loads
	always_ff @(posedge clk) begin
		if (load) begin
			out_tag        <= q_tag;
			out_taken      <= takb;
			out_next_pc    <= next_pc;
			// A wrong direction guess is all that counts as a mispredict here
			out_mispredict <= (takb != q_pred_taken);
		end
	end

endmodule

/* bru_top.sv */
/*
 * Top level of the branch resolution unit.
 * Connects the issue queue, the width-selecting evaluator and the resolver.
 */

`timescale 1ns/1ps
`include "bru_macros.svh"

module bru_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   in_valid,
	output logic                   in_ready,
	input  logic [`BRU_TAG_W-1:0]  in_tag,
	input  logic [`BRU_PC_W-1:0]   in_pc,
	input  logic                   in_pred_taken,
	input  bru_pkg::micro_op_t     in_uop,
	input  logic [`BRU_DATA_W-1:0] in_a,
	input  logic [`BRU_DATA_W-1:0] in_b,
	input  logic                   in_c,
	output logic                   out_valid,
	input  logic                   out_ready,
	output logic [`BRU_TAG_W-1:0]  out_tag,
	output logic                   out_taken,
	output logic [`BRU_PC_W-1:0]   out_next_pc,
	output logic                   out_mispredict
);

	// Head of the queue, shared by the evaluator and the resolver
	logic                   q_valid;
	logic                   q_ready;
	logic [`BRU_TAG_W-1:0]  q_tag;
	logic [`BRU_PC_W-1:0]   q_pc;
	logic                   q_pred_taken;
	bru_pkg::micro_op_t     q_uop;
	logic [`BRU_DATA_W-1:0] q_a;
	logic [`BRU_DATA_W-1:0] q_b;
	logic                   q_c;
	logic                   takb;

	bru_issue_queue u_queue (
		.clk(clk), .rst_n(rst_n),
		.in_valid(in_valid), .in_tag(in_tag), .in_pc(in_pc),
		.in_pred_taken(in_pred_taken), .in_uop(in_uop),
		.in_a(in_a), .in_b(in_b), .in_c(in_c), .in_ready(in_ready),
		.q_valid(q_valid), .q_tag(q_tag), .q_pc(q_pc), .q_pred_taken(q_pred_taken),
		.q_uop(q_uop), .q_a(q_a), .q_b(q_b), .q_c(q_c), .q_ready(q_ready)
	);

	// Condition is resolved in the same cycle the head is presented
	bru_meta_eval u_eval (.uop(q_uop), .a(q_a), .b(q_b), .c(q_c), .takb(takb));

	bru_resolve u_resolve (
		.clk(clk), .rst_n(rst_n),
		.q_valid(q_valid), .q_tag(q_tag), .q_pc(q_pc), .q_pred_taken(q_pred_taken),
		.q_uop(q_uop), .takb(takb), .q_ready(q_ready),
		.out_valid(out_valid), .out_tag(out_tag), .out_taken(out_taken),
		.out_next_pc(out_next_pc), .out_mispredict(out_mispredict), .out_ready(out_ready)
	);

endmodule

/* bru_properties.sv */
/*
 * Concurrent handshake and reset checks for the branch unit.
 * Bound into bru_top at the bottom of this file.
 */

`timescale 1ns/1ps
`include "bru_macros.svh"

module bru_properties (
	input logic                  clk,
	input logic                  rst_n,
	input logic                  q_valid,
	input logic                  q_ready,
	input logic                  out_valid,
	input logic                  out_ready,
	input logic [`BRU_TAG_W-1:0] out_tag,
	input logic                  out_taken,
	input logic [`BRU_PC_W-1:0]  out_next_pc,
	input logic                  out_mispredict
);

	// The output slot stays empty while reset is held
	assert property (@(posedge clk) !rst_n |-> !out_valid)
		else $error("out_valid is high during reset");

	// A stalled result keeps its valid and every payload bit
	assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_tag) && $stable(out_taken)
			&& $stable(out_next_pc) && $stable(out_mispredict))
		else $error("stalled output changed before it was taken");

	// The queue head may only leave through a transfer
	assert property (@(posedge clk) disable iff (!rst_n) q_valid && !q_ready |=> q_valid)
		else $error("q_valid dropped without a transfer");

endmodule

bind bru_top bru_properties u_props (
	.clk(clk), .rst_n(rst_n), .q_valid(q_valid), .q_ready(q_ready),
	.out_valid(out_valid), .out_ready(out_ready), .out_tag(out_tag),
	.out_taken(out_taken), .out_next_pc(out_next_pc), .out_mispredict(out_mispredict)
);

/* bru_tb_clock.sv */
/*
 * Free-running testbench clock for the branch unit, 40 ns period.
 */

`timescale 1ns/1ps

module bru_tb_clock (
	output logic clk
);

	// The clock starts low and toggles every 20 ns
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

endmodule

/* bru_tb.sv */
/*
 * Directed testbench for the branch resolution unit.
 * Drives micro-ops on the falling edge and scores results against a reference model.
 */

`timescale 1ns/1ps
`include "bru_macros.svh"

module bru_tb;

	// Tests add up to roughly 1500 cycles, so 4000 leaves a wide margin
	localparam int TIMEOUT_CYCLES = 4000;
	localparam bit [31:0] SEED = 32'h492d_cc42;
	localparam bru_pkg::opcode_t OPS [8] = '{bru_pkg::OP_BCC8, bru_pkg::OP_BCC16,
		bru_pkg::OP_BCC32, bru_pkg::OP_BCC64, bru_pkg::OP_BCCU8, bru_pkg::OP_BCCU16,
		bru_pkg::OP_BCCU32, bru_pkg::OP_BCCU64};

	logic clk;
	logic rst_n;
	logic in_valid;
	logic in_ready;
	logic [`BRU_TAG_W-1:0] in_tag;
	logic [`BRU_PC_W-1:0] in_pc;
	logic in_pred_taken;
	bru_pkg::micro_op_t in_uop;
	logic [`BRU_DATA_W-1:0] in_a;
	logic [`BRU_DATA_W-1:0] in_b;
	logic in_c;
	logic out_valid;
	logic out_ready;
	logic [`BRU_TAG_W-1:0] out_tag;
	logic out_taken;
	logic [`BRU_PC_W-1:0] out_next_pc;
	logic out_mispredict;

	// Scoreboard of results still owed by the DUT with the oldest first
	logic [`BRU_TAG_W-1:0] exp_tag [$];
	logic exp_taken [$];
	logic [`BRU_PC_W-1:0] exp_pc [$];
	logic exp_misp [$];

	logic [`BRU_TAG_W-1:0] next_tag;
	logic bp_random;
	string cur_test;
	int test_err0;
	int tests;
	int checks;
	int errors;
	int outputs;
	int cyc;

	bru_tb_clock u_clock (.clk(clk));

	bru_top DUT (
		.clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_ready(in_ready),
		.in_tag(in_tag), .in_pc(in_pc), .in_pred_taken(in_pred_taken), .in_uop(in_uop),
		.in_a(in_a), .in_b(in_b), .in_c(in_c), .out_valid(out_valid), .out_ready(out_ready),
		.out_tag(out_tag), .out_taken(out_taken), .out_next_pc(out_next_pc),
		.out_mispredict(out_mispredict)
	);

	// ======================================================================
	// Reference model
	// ======================================================================

	// Operands are cut to the opcode width, then widened by one bit
	// A signed compare on the widened values covers both families
	function automatic logic ref_taken(bru_pkg::micro_op_t u, logic [`BRU_DATA_W-1:0] a,
			logic [`BRU_DATA_W-1:0] b, logic c);
		int w;
		logic sgn;
		logic t;
		logic [`BRU_DATA_W-1:0] mask;
		logic [`BRU_DATA_W-1:0] am;
		logic [`BRU_DATA_W-1:0] bm;
		logic signed [`BRU_DATA_W:0] sa;
		logic signed [`BRU_DATA_W:0] sb;
		case (u.br.opcode)
			bru_pkg::OP_BCC8, bru_pkg::OP_BCCU8: w = 8;
			bru_pkg::OP_BCC16, bru_pkg::OP_BCCU16: w = 16;
			bru_pkg::OP_BCC32, bru_pkg::OP_BCCU32: w = 32;
			bru_pkg::OP_BCC64, bru_pkg::OP_BCCU64: w = 64;
			default: w = 0;
		endcase
		if (w == 0)
			return 1'b0;
		sgn = u.br.opcode inside {bru_pkg::OP_BCC8, bru_pkg::OP_BCC16, bru_pkg::OP_BCC32,
			bru_pkg::OP_BCC64};
		mask = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
		am = a & mask;
		bm = b & mask;
		if (sgn && am[w-1])
			am = am | ~mask;
		if (sgn && bm[w-1])
			bm = bm | ~mask;
		sa = {sgn & am[63], am};
		sb = {sgn & bm[63], bm};
		case (u.br.cond)
			bru_pkg::EQ: t = (sa == sb);
			bru_pkg::NE: t = (sa != sb);
			bru_pkg::LT: t = (sa < sb);
			bru_pkg::GE: t = (sa >= sb);
			bru_pkg::LE: t = (sa <= sb);
			bru_pkg::GT: t = (sa > sb);
			bru_pkg::FS: t = c;
			default: t = !c;
		endcase
		return t;
	endfunction

	// A size cast of a signed value sign extends the displacement
	function automatic logic [`BRU_PC_W-1:0] ref_next_pc(logic [`BRU_PC_W-1:0] pc,
			logic signed [`BRU_DISP_W-1:0] disp, logic taken);
		logic [`BRU_PC_W-1:0] ext;
		ext = `BRU_PC_W'(disp);
		return taken ? pc + ext : pc + `BRU_INSN_BYTES;
	endfunction

	function automatic bru_pkg::micro_op_t make_uop(bru_pkg::opcode_t op, bru_pkg::cond_t cd,
			logic [`BRU_DISP_W-1:0] disp);
		bru_pkg::micro_op_t u;
		u.br.opcode = op;
		u.br.cond = cd;
		u.br.spare = '0;
		u.br.disp = disp;
		return u;
	endfunction

	// ======================================================================
	// Compare tasks
	// ======================================================================

	task automatic check_taken(input string what, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s %s: expected %0b, actual %0b", cur_test, what, exp, act);
		end
	endtask

	task automatic check_pc(input string what, input logic [`BRU_PC_W-1:0] exp,
			input logic [`BRU_PC_W-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s %s: expected %08h, actual %08h", cur_test, what, exp, act);
		end
	endtask

	task automatic check_tag(input string what, input logic [`BRU_TAG_W-1:0] exp,
			input logic [`BRU_TAG_W-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
		end
	endtask

	// Every result leaving the DUT is scored against the oldest expectation
	always @(posedge clk) begin
		if (rst_n && out_valid && out_ready) begin
			outputs++;
			if (exp_tag.size() == 0) begin
				errors++;
				$display("[ERROR] %s: a result with tag %0h came out with nothing pending",
					cur_test, out_tag);
			end else begin
				check_tag("tag", exp_tag.pop_front(), out_tag);
				check_taken("taken", exp_taken.pop_front(), out_taken);
				check_pc("next_pc", exp_pc.pop_front(), out_next_pc);
				check_taken("mispredict", exp_misp.pop_front(), out_mispredict);
			end
		end
	end

	// Watchdog on total run length
	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= TIMEOUT_CYCLES) begin
			$display("Timeout in test %s: the run did not finish within %0d cycles",
				cur_test, TIMEOUT_CYCLES);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// ======================================================================
	// Drivers
	// ======================================================================

	// Called at each falling edge and changes out_ready only in random mode
	task automatic drive_ready();
		if (bp_random)
			out_ready = 1'($urandom);
	endtask

	// Entered and left at a falling edge; in_ready is read before the edge settles
	task automatic issue_uop(input logic [`BRU_PC_W-1:0] pc, input logic pred,
			input bru_pkg::micro_op_t u, input logic [`BRU_DATA_W-1:0] a,
			input logic [`BRU_DATA_W-1:0] b, input logic c);
		logic taken;
		taken = ref_taken(u, a, b, c);
		exp_tag.push_back(next_tag);
		exp_taken.push_back(taken);
		exp_pc.push_back(ref_next_pc(pc, u.br.disp, taken));
		exp_misp.push_back(taken != pred);
		in_valid = 1'b1;
		in_tag = next_tag;
		in_pc = pc;
		in_pred_taken = pred;
		in_uop = u;
		in_a = a;
		in_b = b;
		in_c = c;
		@(posedge clk);
		while (!in_ready) begin
			@(negedge clk);
			drive_ready();
			@(posedge clk);
		end
		next_tag = next_tag + 1'b1;
		@(negedge clk);
		drive_ready();
		in_valid = 1'b0;
	endtask

	task automatic wait_drained();
		while (exp_tag.size() != 0) begin
			@(negedge clk);
			drive_ready();
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_err0 = errors;
	endtask

	task automatic finish_test();
		wait_drained();
		tests++;
		$display("Test %s finished with %0d errors", cur_test, errors - test_err0);
	endtask

	// ======================================================================
	// Directed tests
	// ======================================================================

	task automatic reset_state();
		start_test("reset");
		check_taken("out_valid", 1'b0, out_valid);
		check_taken("in_ready", 1'b1, in_ready);
		finish_test();
	endtask

	// Pair 0 flips the sign at every width and pair 1 differs only above 16 bits
	// In pair 0 the compare direction also turns over from each width to the next
	task automatic sweep_conditions();
		logic [`BRU_DATA_W-1:0] pa [4];
		logic [`BRU_DATA_W-1:0] pb [4];
		start_test("conditions");
		pa[0] = 64'h1234_5678_9abc_5e80;
		pb[0] = 64'h8765_4321_0fed_cb01;
		pa[1] = 64'hffff_0000_ff00_7f7f;
		pb[1] = 64'h0000_ffff_0000_7f7f;
		pa[2] = 64'h8000_0000_8000_8080;
		pb[2] = 64'h8000_0000_8000_8080;
		pa[3] = {$urandom, $urandom};
		pb[3] = {$urandom, $urandom};
		for (int p = 0; p < 4; p++)
			for (int o = 0; o < 8; o++)
				for (int k = 0; k < 8; k++)
					issue_uop(32'h0000_2000 + 32'(p * 256), 1'(k), make_uop(OPS[o],
						bru_pkg::cond_t'(3'(k)), 16'h0040), pa[p], pb[p], 1'(p));
		finish_test();
	endtask

	// Equal operands would branch on EQ if any of these were a branch
	task automatic non_branch_ops();
		logic [6:0] codes [4];
		start_test("non_branch");
		codes[0] = 7'h00;
		codes[1] = 7'h2f;
		codes[2] = 7'h38;
		codes[3] = 7'h7f;
		for (int i = 0; i < 4; i++)
			issue_uop(32'h0000_3000, 1'b1, make_uop(bru_pkg::opcode_t'(codes[i]), bru_pkg::EQ,
				16'h0100), 64'h5, 64'h5, 1'b1);
		finish_test();
	endtask

	// FS with c steers the direction so the displacement alone shapes the target
	task automatic target_and_mispredict();
		logic [`BRU_DISP_W-1:0] disps [4];
		start_test("target");
		disps[0] = 16'h0010;
		disps[1] = 16'hfff0;
		disps[2] = 16'h7ffc;
		disps[3] = 16'h8000;
		for (int d = 0; d < 4; d++)
			for (int t = 0; t < 2; t++)
				for (int pr = 0; pr < 2; pr++)
					issue_uop(32'h8000_0004, 1'(pr), make_uop(bru_pkg::OP_BCC32, bru_pkg::FS,
						disps[d]), 64'h0, 64'h0, 1'(t));
		finish_test();
	endtask

	task automatic random_backpressure();
		int first;
		start_test("backpressure");
		first = outputs;
		bp_random = 1'b1;
		for (int i = 0; i < 200; i++) begin
			// Occasional idle cycle on the issue side
			if ($urandom % 4 == 0) begin
				@(negedge clk);
				drive_ready();
			end
			issue_uop($urandom, 1'($urandom), make_uop(OPS[$urandom_range(7, 0)],
				bru_pkg::cond_t'(3'($urandom)), 16'($urandom)), {$urandom, $urandom},
				{$urandom, $urandom}, 1'($urandom));
		end
		bp_random = 1'b0;
		out_ready = 1'b1;
		wait_drained();
		if (outputs - first != 200) begin
			errors++;
			$display("[ERROR] %s output count: expected 200, actual %0d", cur_test,
				outputs - first);
		end
		finish_test();
	endtask

	// Acceptance is edge N and the result must be seen at edge N+2
	task automatic idle_latency();
		int n;
		start_test("latency");
		out_ready = 1'b1;
		issue_uop(32'h0000_4000, 1'b0, make_uop(bru_pkg::OP_BCC64, bru_pkg::EQ, 16'h0008),
			64'h1, 64'h1, 1'b0);
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (!out_valid && n < 8);
		if (n != 2) begin
			errors++;
			$display("[ERROR] %s edges to out_valid: expected 2, actual %0d", cur_test, n);
		end
		@(negedge clk);
		finish_test();
	endtask

	initial begin
		void'($urandom(SEED));
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_tag = '0;
		in_pc = '0;
		in_pred_taken = 1'b0;
		in_uop = '0;
		in_a = '0;
		in_b = '0;
		in_c = 1'b0;
		out_ready = 1'b1;
		next_tag = '0;
		bp_random = 1'b0;
		cur_test = "startup";
		tests = 0;
		checks = 0;
		errors = 0;
		outputs = 0;
		cyc = 0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		reset_state();
		sweep_conditions();
		non_branch_ops();
		target_and_mispredict();
		random_backpressure();
		idle_latency();
		$display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* bru.f */
+incdir+.
bru_pkg.sv
bru_issue_queue.sv
bru_cond_eval.sv
bru_meta_eval.sv
bru_resolve.sv
bru_top.sv
bru_properties.sv
bru_tb_clock.sv
bru_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile the branch unit testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module bru_tb -f bru.f -o bru_sim
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

./obj_dir/bru_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
	echo "Simulation reported failures"
	exit 1
fi
echo "Simulation passed"
exit 0
